// ==== common/ising_config.svh ====
// Ising annealer configuration
// Spin word width, FIFO depth and sweep count width

`ifndef ISING_CONFIG_SVH
`define ISING_CONFIG_SVH

// Spins per word, one bit each
`define ISING_SPIN_W 16

// Words held in the spin FIFO
`define ISING_DEPTH 4

// Width of the sweep count in a command
`define ISING_SWEEP_W 8

`endif

// ==== common/ising_pkg.sv ====
// Ising annealer shared types
// Spin word, command, opcode, controller state and FIFO usage

`include "ising_config.svh"

package ising_pkg;

    // One bit per spin, 1 is spin up
    typedef logic [`ISING_SPIN_W-1:0] spin_word_t;

    // Host opcodes
    typedef enum logic [0:0] {
        OP_ANNEAL = 1'b0,
        OP_FLUSH  = 1'b1
    } anneal_op_e;

    // Command word on the host channel
    typedef struct packed {
        anneal_op_e                op;
        logic [`ISING_SWEEP_W-1:0] sweeps;
    } anneal_cmd_t;

    // Anneal controller states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_RUN     = 2'd1,
        ST_DRAIN   = 2'd2,
        ST_READOUT = 2'd3
    } ctrl_state_e;

    // Usage count, one bit wider so that full is representable
    typedef logic [$clog2(`ISING_DEPTH):0] usage_t;

endpackage

// ==== spin_fifo/spin_fifo.sv ====
// Spin FIFO
// Circular buffer of spin words with a registered head, a synchronous
// flush and full, empty and usage status

`timescale 1ns/1ns
`include "ising_config.svh"

module spin_fifo (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  ising_pkg::spin_word_t data_i,
    input  logic                  pop_i,
    output ising_pkg::spin_word_t data_o,
    output logic                  full_o,
    output logic                  empty_o,
    output ising_pkg::usage_t     usage_o
);
    import ising_pkg::*;

    localparam int PTR_W = (`ISING_DEPTH > 1) ? $clog2(`ISING_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`ISING_DEPTH - 1);

    // Circular storage and its pointers
    spin_word_t       mem_q [`ISING_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    usage_t           usage_q;

    // Pointers and usage
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push_i && !pop_i) begin
                usage_q <= usage_q + 1'b1;
            end else if (pop_i && !push_i) begin
                usage_q <= usage_q - 1'b1;
            end
        end
    end

    // Word storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Head is read straight from storage and never from data_i
    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (usage_q == usage_t'(`ISING_DEPTH));
    assign empty_o = (usage_q == '0);
    assign usage_o = usage_q;

    // Callers must respect full and empty
    ap_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i |-> !full_o);
    ap_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_i |-> !empty_o);

endmodule

// ==== spin_fifo/spin_fifo_maintainer.sv ====
// Spin FIFO maintainer
// Chooses the FIFO push source, routes pops to the update engine or the
// host readout and keeps the anneal busy flag

`timescale 1ns/1ns
`include "ising_config.svh"

module spin_fifo_maintainer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  cmpt_en_i,
    input  logic                  anneal_finish_i,
    input  logic                  host_readout_i,
    input  logic                  host_push_valid_i,
    input  ising_pkg::spin_word_t host_push_i,
    input  logic                  upd_valid_i,
    input  ising_pkg::spin_word_t upd_spin_i,
    input  logic                  out_ready_i,
    output logic                  host_push_ready_o,
    output logic                  eng_pop_valid_o,
    output ising_pkg::spin_word_t pop_spin_o,
    output logic                  out_valid_o,
    output logic                  cmpt_busy_o,
    output logic                  fifo_full_o,
    output logic                  fifo_empty_o
);
    import ising_pkg::*;

    logic       cmpt_busy_q;
    logic       cmpt_stop;
    logic       fifo_push;
    logic       fifo_pop;
    spin_word_t push_spin;
    usage_t     fifo_usage;

    spin_fifo u_spin_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .push_i  (fifo_push),
        .data_i  (push_spin),
        .pop_i   (fifo_pop),
        .data_o  (pop_spin_o),
        .full_o  (fifo_full_o),
        .empty_o (fifo_empty_o),
        .usage_o (fifo_usage)
    );

    // Anneal ends once the last updated word is back and the FIFO is full
    assign cmpt_stop = anneal_finish_i & fifo_full_o;

    // Host may only push outside an anneal and outside readout
    assign host_push_ready_o = ~cmpt_busy_q & ~fifo_full_o & ~host_readout_i & ~flush_i;

    // Update unit owns the write port while busy
    assign push_spin = cmpt_busy_q ? upd_spin_i : host_push_i;
    assign fifo_push = cmpt_busy_q ? upd_valid_i : (host_push_valid_i & host_push_ready_o);

    // Engine pops are always taken while host pops wait for ready
    assign eng_pop_valid_o = cmpt_busy_q & ~anneal_finish_i & ~fifo_empty_o;
    assign out_valid_o     = host_readout_i & ~fifo_empty_o;
    assign fifo_pop        = eng_pop_valid_o | (out_valid_o & out_ready_i);

    assign cmpt_busy_o = cmpt_busy_q;

    // Clear of the busy flag wins over set
    always_ff @(posedge clk_i) begin
        if (reset_i || cmpt_stop || flush_i) begin
            cmpt_busy_q <= 1'b0;
        end else if (cmpt_en_i) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    // Pop and delayed push keep at most one word in flight during a sweep
    ap_sweep_occupancy: assert property (@(posedge clk_i) disable iff (reset_i)
        (cmpt_busy_q && !anneal_finish_i) |-> (fifo_usage >= usage_t'(`ISING_DEPTH - 1)));

endmodule

// ==== hw/sweep_counter.sv ====
// Sweep counter
// Counts engine pops per word position and per sweep and flags the
// final pop of an anneal

`timescale 1ns/1ns
`include "ising_config.svh"

module sweep_counter (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      load_i,
    input  logic [`ISING_SWEEP_W-1:0] sweeps_i,
    input  logic                      step_i,
    output logic                      last_pop_o
);
    localparam int WORD_W = (`ISING_DEPTH > 1) ? $clog2(`ISING_DEPTH) : 1;
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`ISING_DEPTH - 1);

    logic [WORD_W-1:0]         word_cnt_q;
    logic [`ISING_SWEEP_W-1:0] sweeps_left_q;
    logic                      armed_q;
    logic                      sweep_end;

    assign sweep_end  = step_i & (word_cnt_q == LAST_WORD);
    // Final word of the final sweep
    assign last_pop_o = armed_q & sweep_end & (sweeps_left_q == 1);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            word_cnt_q    <= '0;
            sweeps_left_q <= '0;
            armed_q       <= 1'b0;
        end else if (load_i) begin
            word_cnt_q    <= '0;
            sweeps_left_q <= sweeps_i;
            armed_q       <= 1'b1;
        end else if (step_i) begin
            word_cnt_q <= sweep_end ? '0 : word_cnt_q + 1'b1;
            if (sweep_end) begin
                sweeps_left_q <= sweeps_left_q - 1'b1;
            end
            if (last_pop_o) begin
                armed_q <= 1'b0;
            end
        end
    end

    // Engine must not pop outside a loaded anneal
    ap_step_armed: assert property (@(posedge clk_i) disable iff (reset_i)
        step_i |-> armed_q);

endmodule

// ==== hw/spin_update.sv ====
// Spin update unit
// Registered ring majority update of one spin word, one word per cycle

`timescale 1ns/1ns

module spin_update (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  in_valid_i,
    input  ising_pkg::spin_word_t in_spin_i,
    output logic                  out_valid_o,
    output ising_pkg::spin_word_t out_spin_o
);
    import ising_pkg::*;

    localparam int W = $bits(spin_word_t);

    spin_word_t maj_spin;

    // Each spin takes the majority of left, self and right, wrapping at the edges
    always_comb begin
        for (int i = 0; i < W; i++) begin
            maj_spin[i] = (in_spin_i[(i + 1) % W] & in_spin_i[i])
                        | (in_spin_i[i] & in_spin_i[(i + W - 1) % W])
                        | (in_spin_i[(i + 1) % W] & in_spin_i[(i + W - 1) % W]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
        end
    end

    // Result word, qualified by out_valid_o
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            out_spin_o <= maj_spin;
        end
    end

endmodule

// ==== hw/anneal_ctrl.sv ====
// Anneal controller
// Accepts host commands, starts and finishes an anneal and hands the
// FIFO to the host for readout

`timescale 1ns/1ns

module anneal_ctrl (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   cmd_valid_i,
    input  ising_pkg::anneal_cmd_t cmd_i,
    input  logic                   fifo_full_i,
    input  logic                   cmpt_busy_i,
    input  logic                   last_pop_i,
    input  logic                   fifo_empty_i,
    output logic                   cmd_ready_o,
    output logic                   flush_o,
    output logic                   cmpt_en_o,
    output logic                   cnt_load_o,
    output logic                   anneal_finish_o,
    output logic                   host_readout_o,
    output logic                   busy_o,
    output logic                   done_o
);
    import ising_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        cmd_fire;
    logic        anneal_go;
    logic        run_go;
    logic        read_go;
    logic        drain_done;

    // Commands only in idle, and not while a flush is applied
    assign cmd_ready_o = (state_q == ST_IDLE) & ~flush_o;
    assign cmd_fire    = cmd_valid_i & cmd_ready_o;

    // Anneal on a partly filled FIFO is taken and dropped
    assign anneal_go = cmd_fire & (cmd_i.op == OP_ANNEAL) & fifo_full_i;
    assign run_go    = anneal_go & (cmd_i.sweeps != '0);
    // Zero sweeps goes straight to readout
    assign read_go   = anneal_go & (cmd_i.sweeps == '0);

    assign cmpt_en_o  = run_go;
    assign cnt_load_o = run_go;

    // Finish is held through drain so no new engine pop starts
    assign anneal_finish_o = (state_q == ST_DRAIN);
    assign host_readout_o  = (state_q == ST_READOUT);
    assign drain_done      = (state_q == ST_DRAIN) & ~cmpt_busy_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (run_go) begin
                    state_d = ST_RUN;
                end else if (read_go) begin
                    state_d = ST_READOUT;
                end
            end
            ST_RUN:     if (last_pop_i)   state_d = ST_DRAIN;
            ST_DRAIN:   if (!cmpt_busy_i) state_d = ST_READOUT;
            ST_READOUT: if (fifo_empty_i) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // Flush lands one cycle after the command
            flush_o <= cmd_fire & (cmd_i.op == OP_FLUSH);
            // Single cycle pulse as readout opens
            done_o  <= drain_done;
            if (run_go) begin
                busy_o <= 1'b1;
            end else if (drain_done) begin
                busy_o <= 1'b0;
            end
        end
    end

    // Start needs a full FIFO and the maintainer must pick it up next cycle
    ap_start_full: assert property (@(posedge clk_i) disable iff (reset_i)
        cmpt_en_o |-> fifo_full_i ##1 cmpt_busy_i);

endmodule

// ==== hw/ising_core.sv ====
// Ising annealer core
// Connects the controller, sweep counter, FIFO maintainer and update unit
// to the host command, spin input and readout channels

`timescale 1ns/1ns

module ising_core (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   cmd_valid_i,
    input  ising_pkg::anneal_cmd_t cmd_i,
    output logic                   cmd_ready_o,
    input  logic                   in_valid_i,
    input  ising_pkg::spin_word_t  in_spin_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    output ising_pkg::spin_word_t  out_spin_o,
    input  logic                   out_ready_i,
    output logic                   busy_o,
    output logic                   done_o
);
    import ising_pkg::*;

    logic       flush, cmpt_en, cnt_load, anneal_finish, host_readout;
    logic       eng_pop_valid, upd_valid, last_pop;
    logic       cmpt_busy, fifo_full, fifo_empty;
    spin_word_t pop_spin;
    spin_word_t upd_spin;

    anneal_ctrl u_anneal_ctrl (
        .clk_i(clk_i), .reset_i(reset_i), .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
        .fifo_full_i(fifo_full), .cmpt_busy_i(cmpt_busy), .last_pop_i(last_pop),
        .fifo_empty_i(fifo_empty), .cmd_ready_o(cmd_ready_o), .flush_o(flush),
        .cmpt_en_o(cmpt_en), .cnt_load_o(cnt_load), .anneal_finish_o(anneal_finish),
        .host_readout_o(host_readout), .busy_o(busy_o), .done_o(done_o)
    );

    // Every engine pop is one counter step
    sweep_counter u_sweep_counter (
        .clk_i(clk_i), .reset_i(reset_i), .load_i(cnt_load), .sweeps_i(cmd_i.sweeps),
        .step_i(eng_pop_valid), .last_pop_o(last_pop)
    );

    spin_fifo_maintainer u_spin_fifo_maintainer (
        .clk_i(clk_i), .reset_i(reset_i), .flush_i(flush), .cmpt_en_i(cmpt_en),
        .anneal_finish_i(anneal_finish), .host_readout_i(host_readout),
        .host_push_valid_i(in_valid_i), .host_push_i(in_spin_i),
        .upd_valid_i(upd_valid), .upd_spin_i(upd_spin), .out_ready_i(out_ready_i),
        .host_push_ready_o(in_ready_o), .eng_pop_valid_o(eng_pop_valid),
        .pop_spin_o(pop_spin), .out_valid_o(out_valid_o), .cmpt_busy_o(cmpt_busy),
        .fifo_full_o(fifo_full), .fifo_empty_o(fifo_empty)
    );

    spin_update u_spin_update (
        .clk_i(clk_i), .reset_i(reset_i), .in_valid_i(eng_pop_valid), .in_spin_i(pop_spin),
        .out_valid_o(upd_valid), .out_spin_o(upd_spin)
    );

    // FIFO head is the readout word
    assign out_spin_o = pop_spin;

endmodule

// ==== tb/ising_core_tb.sv ====
// Ising annealer core testbench
// Directed tests with a ring-majority reference model and random spin words

`timescale 1ns/1ns
`include "ising_config.svh"

module ising_core_tb;
    import ising_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int W       = `ISING_SPIN_W;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    anneal_cmd_t cmd;
    logic        cmd_ready;
    logic        in_valid;
    spin_word_t  in_spin;
    logic        in_ready;
    logic        out_valid;
    spin_word_t  out_spin;
    logic        out_ready;
    logic        busy;
    logic        done;
    logic [31:0] lcg_state;
    // Words of the current test in load order
    spin_word_t  words [`ISING_DEPTH];

    ising_core u_ising_core (
        .clk_i       (clk),
        .reset_i     (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .cmd_ready_o (cmd_ready),
        .in_valid_i  (in_valid),
        .in_spin_i   (in_spin),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_spin_o  (out_spin),
        .out_ready_i (out_ready),
        .busy_o      (busy),
        .done_o      (done)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Each spin becomes the vote of its two ring neighbours and itself
    function automatic spin_word_t ring_majority(spin_word_t w, int sweeps);
        spin_word_t cur;
        spin_word_t nxt;
        int         votes;
        cur = w;
        for (int s = 0; s < sweeps; s++) begin
            for (int i = 0; i < W; i++) begin
                votes  = cur[(i + W - 1) % W] + cur[i] + cur[(i + 1) % W];
                nxt[i] = (votes >= 2);
            end
            cur = nxt;
        end
        return cur;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_spin(string what, spin_word_t got, spin_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // All handshake tasks start and end on a falling edge
    task automatic push_word(spin_word_t w);
        int n;
        n = 0;
        while (!in_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for in_ready_o");
        end
        in_valid = 1'b1;
        in_spin  = w;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_cmd(anneal_op_e op, logic [`ISING_SWEEP_W-1:0] sweeps);
        int n;
        n = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for cmd_ready_o");
        end
        cmd_valid  = 1'b1;
        cmd.op     = op;
        cmd.sweeps = sweeps;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic load_words();
        for (int i = 0; i < `ISING_DEPTH; i++) begin
            push_word(words[i]);
        end
    endtask

    task automatic random_words();
        for (int i = 0; i < `ISING_DEPTH; i++) begin
            words[i] = spin_word_t'(lcg_next() >> 16);
        end
    endtask

    // Host channels must stay closed for the whole anneal
    task automatic wait_done();
        int n;
        n = 0;
        while (!done) begin
            if (busy) begin
                check_flag("in_ready_o while busy", in_ready, 1'b0);
                check_flag("cmd_ready_o while busy", cmd_ready, 1'b0);
            end
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for done_o");
        end
        check_flag("busy_o with done_o", busy, 1'b0);
        @(negedge clk);
        check_flag("done_o after its pulse", done, 1'b0);
    endtask

    // Reads every word with optional stalls and checks that the FIFO ends empty
    task automatic read_words(int sweeps, bit stalls);
        int         n;
        int         hold;
        spin_word_t seen;
        for (int i = 0; i < `ISING_DEPTH; i++) begin
            n = 0;
            while (!out_valid) begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT) fail_run("Timed out waiting for out_valid_o");
            end
            hold = stalls ? int'(lcg_next() >> 30) : 0;
            seen = out_spin;
            repeat (hold) begin
                @(negedge clk);
                check_flag("out_valid_o during stall", out_valid, 1'b1);
                check_spin("out_spin_o during stall", out_spin, seen);
            end
            check_spin("readout word", out_spin, ring_majority(words[i], sweeps));
            out_ready = 1'b1;
            @(negedge clk);
            out_ready = 1'b0;
        end
        check_flag("out_valid_o after last word", out_valid, 1'b0);
    endtask

    task automatic idle_after_reset();
        check_flag("cmd_ready_o after reset", cmd_ready, 1'b1);
        check_flag("in_ready_o after reset", in_ready, 1'b1);
        check_flag("busy_o after reset", busy, 1'b0);
        check_flag("done_o after reset", done, 1'b0);
        check_flag("out_valid_o after reset", out_valid, 1'b0);
    endtask

    task automatic single_sweep_anneal();
        // Lone spins flip and solid runs survive
        words[0] = 16'h0001;
        words[1] = 16'hF0F0;
        words[2] = 16'hA5A5;
        words[3] = 16'h7FFE;
        load_words();
        send_cmd(OP_ANNEAL, 1);
        check_flag("busy_o after anneal start", busy, 1'b1);
        wait_done();
        read_words(1, 1'b0);
    endtask

    task automatic random_sweeps_with_stalls();
        random_words();
        load_words();
        send_cmd(OP_ANNEAL, 3);
        check_flag("busy_o after anneal start", busy, 1'b1);
        wait_done();
        read_words(3, 1'b1);
    endtask

    task automatic host_blocked_while_busy();
        random_words();
        load_words();
        send_cmd(OP_ANNEAL, 2);
        // Offer a word and a flush that must both be ignored
        in_valid   = 1'b1;
        in_spin    = 16'hFFFF;
        cmd_valid  = 1'b1;
        cmd.op     = OP_FLUSH;
        cmd.sweeps = '0;
        repeat (3) begin
            check_flag("busy_o during anneal", busy, 1'b1);
            check_flag("in_ready_o during anneal", in_ready, 1'b0);
            check_flag("cmd_ready_o during anneal", cmd_ready, 1'b0);
            @(negedge clk);
        end
        in_valid  = 1'b0;
        cmd_valid = 1'b0;
        wait_done();
        read_words(2, 1'b0);
    endtask

    task automatic flush_then_zero_sweeps();
        push_word(16'hDEAD);
        push_word(16'hBEEF);
        send_cmd(OP_FLUSH, 0);
        random_words();
        load_words();
        send_cmd(OP_ANNEAL, 0);
        check_flag("busy_o on zero sweeps", busy, 1'b0);
        read_words(0, 1'b0);
        // Controller is back in idle one cycle after the last pop
        @(negedge clk);
        check_flag("cmd_ready_o after readout", cmd_ready, 1'b1);
    endtask

    task automatic anneal_on_partial_fifo();
        random_words();
        push_word(words[0]);
        push_word(words[1]);
        send_cmd(OP_ANNEAL, 5);
        // The command is dropped and no anneal starts
        check_flag("busy_o after partial anneal", busy, 1'b0);
        @(negedge clk);
        check_flag("busy_o after partial anneal", busy, 1'b0);
        push_word(words[2]);
        push_word(words[3]);
        send_cmd(OP_ANNEAL, 0);
        read_words(0, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        in_valid  = 1'b0;
        in_spin   = '0;
        out_ready = 1'b0;
        lcg_state = 32'h649c_5eab;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        idle_after_reset();
        single_sweep_anneal();
        random_sweeps_with_stalls();
        host_blocked_while_busy();
        flush_then_zero_sweeps();
        anneal_on_partial_fifo();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== ising_core.f ====
+incdir+common
common/ising_pkg.sv
spin_fifo/spin_fifo.sv
spin_fifo/spin_fifo_maintainer.sv
hw/sweep_counter.sv
hw/spin_update.sv
hw/anneal_ctrl.sv
hw/ising_core.sv
tb/ising_core_tb.sv
